//--- rv_core.f
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_regfile.sv
logic/rv_fetch_stage.sv
logic/rv_decode_stage.sv
logic/rv_exec_stage.sv
logic/wb_arbiter.sv
logic/rv_core_top.sv
testbench/tb_clk_gen.sv
testbench/rv_core_props.sv
testbench/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/rv_core_tb.sv
// testbench for the rv32i core that runs a random program against an isa model
`timescale 1ns/10ps

module rv_core_tb import rv_core_pkg::*;;

  localparam int PROG_LEN  = 232;           // 200 random, 31 final stores, halt
  localparam int LIMIT     = PROG_LEN * 12;
  localparam logic [31:0] DATA_BASE = 32'h400; // words below hold the program
  localparam logic [31:0] HALT_ADR  = (PROG_LEN - 1) * 4;

  logic    clk;
  logic    rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int          seed = 32'h8294_88a1;
  logic [31:0] mem [1024];
  logic [31:0] ref_mem [1024];
  bit          load_seen [1024];
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  int          model_stores;
  int          dut_stores;
  int          halt_seen;
  int          wait_left;
  int          cycles;
  int          value_errs;
  int          other_errs;

  tb_clk_gen clk_gen_i (.o_clk(clk));

  rv_core_top rv_core_top_i (
    .i_clk    (clk),
    .i_rst    (rst),
    .o_wb_req (wb_req),
    .i_wb_rsp (wb_rsp)
  );

  bind rv_core_top rv_core_props rv_core_props_i (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_wb_req         (o_wb_req),
    .i_wb_rsp         (i_wb_rsp),
    .i_fetch_req      (fetch_req),
    .i_exec_req       (exec_req),
    .i_fetch_rsp      (fetch_rsp),
    .i_exec_rsp       (exec_rsp),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_ds_to_es_valid (ds_to_es_valid),
    .i_inst_invalid   (u_decode.inst_invalid)
  );

  function automatic int unsigned rnd(input int unsigned n);
    rnd = $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [4:0] rd, input logic [6:0] op);
    enc_i = {imm, rs1, (op == 7'h03) ? 3'b010 : 3'b000, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic sub, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    enc_r = {1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic bne);
    enc_b = {imm[12], imm[10:5], rs2, rs1, 2'b00, bne, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error t=%0t %s expected %h actual %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic build_program;
    int unsigned kind;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    for (int i = 0; i < 1024; i++) mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    mem[0] = enc_i(12'h400, 5'd0, 5'd31, 7'h13); // x31 holds the data base
    for (int i = 1; i < 200; i++) begin
      kind = rnd(100);
      rd = 5'(1 + rnd(30));
      ra = 5'(rnd(32));
      rb = 5'(rnd(32));
      if (kind < 30) mem[i] = enc_i(12'(rnd(4096)), ra, rd, 7'h13);
      else if (kind < 45) mem[i] = enc_r(1'b0, rb, ra, rd);
      else if (kind < 58) mem[i] = enc_r(1'b1, rb, ra, rd);
      else if (kind < 72) mem[i] = enc_i(12'(rnd(64) * 4), 5'd31, rd, 7'h03);
      else if (kind < 86) mem[i] = enc_s(12'(rnd(64) * 4), rb, 5'd31);
      else if (kind < 97) mem[i] = enc_b(13'((rnd(3) + 2) * 4), 5'(rnd(4)), 5'(rnd(4)), kind[0]);
      else mem[i] = enc_j(21'((rnd(3) + 2) * 4), rd);
    end
    for (int r = 1; r < 32; r++) mem[199 + r] = enc_s(12'(512 + 4 * r), 5'(r), 5'd31);
    mem[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    for (int i = 0; i < 1024; i++) ref_mem[i] = mem[i];
  endtask

  // isa model that records every store in program order
  task automatic run_model;
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] adr;
    logic        wr;
    logic        done;
    pc = 32'h0;
    done = 1'b0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int step = 0; step < 4000 && !done; step++) begin
      inst = ref_mem[pc[11:2]];
      a = regs[inst[19:15]];
      b = regs[inst[24:20]];
      wr = 1'b1;
      res = '0;
      case (inst[6:0])
        7'h13: res = a + {{20{inst[31]}}, inst[31:20]};
        7'h33: res = inst[30] ? a - b : a + b;
        7'h03: begin
          adr = a + {{20{inst[31]}}, inst[31:20]};
          res = ref_mem[adr[11:2]];
          load_seen[adr[11:2]] = 1'b1;
        end
        7'h23: begin
          wr = 1'b0;
          adr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          exp_adr.push_back(adr);
          exp_dat.push_back(b);
          ref_mem[adr[11:2]] = b;
        end
        7'h63: begin
          wr = 1'b0;
          if (inst[12] ? (a != b) : (a == b))
            pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0} - 4;
        end
        default: begin
          res = pc + 4; // jal links the next address
          adr = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
          if (adr == '0) done = 1'b1;
          pc = pc + adr - 4;
        end
      endcase
      if (wr && inst[11:7] != 5'd0) regs[inst[11:7]] = res;
      pc = pc + 4;
    end
    model_stores = exp_adr.size();
  endtask

  // slave with 0 to 3 wait states that checks stores as they are acked
  always @(posedge clk) begin
    if (rst) begin
      wb_rsp <= '0;
      wait_left = -1;
    end else begin
      wb_rsp.ack <= 1'b0;
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (wait_left < 0) wait_left = int'(rnd(4));
        if (wait_left == 0) begin
          wait_left = -1;
          wb_rsp.ack <= 1'b1;
          check_value("wb_sel", 32'h0000_000f, 32'(wb_req.sel));
          if (wb_req.adr > 32'hffc) begin
            $display("access outside memory at %h", wb_req.adr);
            other_errs++;
          end else if (wb_req.we) begin
            dut_stores++;
            if (wb_req.adr < DATA_BASE) begin
              $display("store into program area at %h", wb_req.adr);
              other_errs++;
            end
            if (exp_adr.size() == 0) begin
              $display("extra store at %h beyond the expected list", wb_req.adr);
              other_errs++;
            end else begin
              check_value("wb_adr", exp_adr.pop_front(), wb_req.adr);
              check_value("wb_dat_w", exp_dat.pop_front(), wb_req.dat_w);
            end
            mem[wb_req.adr[11:2]] = wb_req.dat_w;
          end else begin
            wb_rsp.dat_r <= mem[wb_req.adr[11:2]];
            if (wb_req.adr == HALT_ADR) halt_seen++;
            if (wb_req.adr >= DATA_BASE && !load_seen[wb_req.adr[11:2]]) begin
              $display("read at %h that no load of the program makes", wb_req.adr);
              other_errs++;
            end
          end
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    rst <= 1'b1;
    wb_rsp <= '0;
    value_errs = 0;
    other_errs = 0;
    dut_stores = 0;
    halt_seen = 0;
    cycles = 0;
    build_program();
    run_model();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    while (halt_seen < 2 && cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (halt_seen < 2) begin
      $display("timeout, halt loop not reached within %0d cycles", LIMIT);
      other_errs++;
    end
    repeat (4) @(posedge clk);
    check_value("store_count", 32'(model_stores), 32'(dut_stores));
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- testbench/rv_core_props.sv
// bus, handshake and decode assertions for the rv32i core top
`timescale 1ns/10ps

module rv_core_props import rv_core_pkg::*; (
  input logic    i_clk,
  input logic    i_rst,
  input wb_req_t i_wb_req,
  input wb_rsp_t i_wb_rsp,
  input wb_req_t i_fetch_req,
  input wb_req_t i_exec_req,
  input wb_rsp_t i_fetch_rsp,
  input wb_rsp_t i_exec_rsp,
  input logic    i_fs_to_ds_valid,
  input logic    i_ds_to_es_valid,
  input logic    i_inst_invalid
);

  // classic cycle stays put until the slave acks
  a_bus_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_wb_req.cyc && i_wb_req.stb && !i_wb_rsp.ack) |=>
      (i_wb_req.cyc && i_wb_req.stb && $stable(i_wb_req.adr) && $stable(i_wb_req.dat_w)))
    else $error("bus request changed before ack");

  // an ack answers the master that held the bus in the cycle before
  a_fetch_ack: assert property (@(posedge i_clk) disable iff (i_rst)
    i_fetch_rsp.ack |-> ($past(i_fetch_req.cyc) && $past(i_wb_req) == $past(i_fetch_req)))
    else $error("fetch acked without grant");

  a_exec_ack: assert property (@(posedge i_clk) disable iff (i_rst)
    i_exec_rsp.ack |-> ($past(i_exec_req.cyc) && $past(i_wb_req) == $past(i_exec_req)))
    else $error("execute acked without grant");

  a_rst_quiet: assert property (@(posedge i_clk)
    (i_rst && $past(i_rst)) |-> (!i_fs_to_ds_valid && !i_ds_to_es_valid && !i_wb_req.cyc))
    else $error("stage valid or bus cycle during reset");

  a_no_invalid: assert property (@(posedge i_clk) disable iff (i_rst) !i_inst_invalid)
    else $error("decoder saw an unsupported instruction");

endmodule

//--- testbench/tb_clk_gen.sv
// clock source for the core testbench, 4 ns period
`timescale 1ns/10ps

module tb_clk_gen (
  output logic o_clk
);

  initial o_clk = 1'b0;
  always #2 o_clk = ~o_clk;

endmodule

//--- logic/rv_core_top.sv
// top of the three stage rv32i core with one shared wishbone port
`timescale 1ns/10ps

module rv_core_top import rv_core_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  output wb_req_t o_wb_req,
  input  wb_rsp_t i_wb_rsp
);

  logic          fs_to_ds_valid;
  fetch_to_dec_t fs_to_ds;
  logic          ds_allowin;
  logic          es_allowin;
  logic          ds_to_es_valid;
  dec_to_exe_t   ds_to_es;
  br_bus_t       br;
  rf_write_t     rf_write;
  reg_addr_t     es_rd;
  logic          es_rd_valid;
  wb_req_t       fetch_req;
  wb_req_t       exec_req;
  wb_rsp_t       fetch_rsp;
  wb_rsp_t       exec_rsp;

  rv_fetch_stage u_fetch (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_ds_allowin     (ds_allowin),
    .o_fs_to_ds_valid (fs_to_ds_valid),
    .o_fs_to_ds       (fs_to_ds),
    .i_br             (br),
    .o_wb_req         (fetch_req),
    .i_wb_rsp         (fetch_rsp)
  );

  rv_decode_stage u_decode (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds       (fs_to_ds),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es       (ds_to_es),
    .o_br             (br),
    .i_rf_write       (rf_write),
    .i_es_rd          (es_rd),
    .i_es_rd_valid    (es_rd_valid)
  );

  rv_exec_stage u_exec (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_ds_to_es_valid (ds_to_es_valid),
    .i_ds_to_es       (ds_to_es),
    .o_es_allowin     (es_allowin),
    .o_rf_write       (rf_write),
    .o_es_rd          (es_rd),
    .o_es_rd_valid    (es_rd_valid),
    .o_wb_req         (exec_req),
    .i_wb_rsp         (exec_rsp)
  );

  wb_arbiter u_arbiter (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_fetch_req (fetch_req),
    .i_exec_req  (exec_req),
    .o_fetch_rsp (fetch_rsp),
    .o_exec_rsp  (exec_rsp),
    .o_wb_req    (o_wb_req),
    .i_wb_rsp    (i_wb_rsp)
  );

endmodule

//--- logic/wb_arbiter.sv
// two master wishbone classic arbiter, execute wins ties and grant holds to ack
`timescale 1ns/10ps

module wb_arbiter import rv_core_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  wb_req_t i_fetch_req,
  input  wb_req_t i_exec_req,
  output wb_rsp_t o_fetch_rsp,
  output wb_rsp_t o_exec_rsp,
  output wb_req_t o_wb_req,
  input  wb_rsp_t i_wb_rsp
);

  grant_e grant;
  grant_e owner;

  // idle bus hands out the grant in the same cycle
  always_comb begin
    owner = grant;
    if (grant == GNT_IDLE) begin
      if (i_exec_req.cyc) owner = GNT_EXEC;
      else if (i_fetch_req.cyc) owner = GNT_FETCH;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) grant <= GNT_IDLE;
    else if (i_wb_rsp.ack) grant <= GNT_IDLE;
    else grant <= owner;
  end

  always_comb begin
    case (owner)
      GNT_EXEC:  o_wb_req = i_exec_req;
      GNT_FETCH: o_wb_req = i_fetch_req;
      default:   o_wb_req = '0;
    endcase
  end

  assign o_fetch_rsp.dat_r = i_wb_rsp.dat_r;
  assign o_fetch_rsp.ack   = i_wb_rsp.ack && (owner == GNT_FETCH);
  assign o_exec_rsp.dat_r  = i_wb_rsp.dat_r;
  assign o_exec_rsp.ack    = i_wb_rsp.ack && (owner == GNT_EXEC);

endmodule

//--- logic/rv_exec_stage.sv
// execute stage with alu, load/store bus access and register writeback
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_exec_stage import rv_core_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_ds_to_es_valid,
  input  dec_to_exe_t i_ds_to_es,
  output logic        o_es_allowin,
  output rf_write_t   o_rf_write,
  output reg_addr_t   o_es_rd,
  output logic        o_es_rd_valid,
  output wb_req_t     o_wb_req,
  input  wb_rsp_t     i_wb_rsp
);

  logic        es_valid;
  dec_to_exe_t es_r;
  exec_state_e state;
  logic        es_mem;
  logic        in_mem;
  logic        es_ready_go;
  word_t       alu_b;
  word_t       alu_res;

  assign es_mem = es_r.is_load || es_r.is_store;
  assign in_mem = i_ds_to_es.is_load || i_ds_to_es.is_store;

  assign es_ready_go  = !es_mem || (state == ES_BUS && i_wb_rsp.ack);
  assign o_es_allowin = !es_valid || es_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) es_valid <= 1'b0;
    else if (o_es_allowin) es_valid <= i_ds_to_es_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) es_r <= i_ds_to_es;
  end

  // bus cycle starts on entry, or one cycle after a previous ack
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ES_IDLE;
    end else begin
      case (state)
        ES_IDLE: begin
          if ((i_ds_to_es_valid && o_es_allowin && in_mem) || (es_valid && es_mem))
            state <= ES_BUS;
        end
        ES_BUS:  if (i_wb_rsp.ack) state <= ES_IDLE;
        default: state <= ES_IDLE;
      endcase
    end
  end

  assign alu_b   = es_mem ? es_r.imm : es_r.src_b;
  assign alu_res = (es_r.alu_op == ALU_SUB) ? es_r.src_a - alu_b : es_r.src_a + alu_b;

  always_comb begin
    o_wb_req       = '0;
    o_wb_req.adr   = {alu_res[`RV_XLEN-1:2], 2'b00}; // word aligned
    o_wb_req.dat_w = es_r.src_b;
    o_wb_req.sel   = 4'hf;
    o_wb_req.we    = es_r.is_store;
    o_wb_req.cyc   = (state == ES_BUS);
    o_wb_req.stb   = (state == ES_BUS);
  end

  assign o_rf_write.wen   = es_valid && es_ready_go && es_r.rf_we;
  assign o_rf_write.waddr = es_r.rd;
  assign o_rf_write.wdata = es_r.is_load ? i_wb_rsp.dat_r : alu_res;

  // finish cycle is covered by regfile write-through
  assign o_es_rd       = es_r.rd;
  assign o_es_rd_valid = es_valid && es_r.rf_we && !es_ready_go;

endmodule

//--- logic/rv_decode_stage.sv
// decode stage with register read, hazard stall and branch resolution
`timescale 1ns/10ps

module rv_decode_stage import rv_core_pkg::*; (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_fs_to_ds_valid,
  input  fetch_to_dec_t i_fs_to_ds,
  output logic          o_ds_allowin,
  input  logic          i_es_allowin,
  output logic          o_ds_to_es_valid,
  output dec_to_exe_t   o_ds_to_es,
  output br_bus_t       o_br,
  input  rf_write_t     i_rf_write,
  input  reg_addr_t     i_es_rd,
  input  logic          i_es_rd_valid
);

  logic          ds_valid;
  logic          ds_ready_go;
  fetch_to_dec_t ds_r;
  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  reg_addr_t     rs1;
  reg_addr_t     rs2;
  reg_addr_t     rd;
  word_t         rs1_data;
  word_t         rs2_data;
  word_t         imm;
  logic          is_addi, is_add, is_sub, is_lw, is_sw, is_beq, is_bne, is_jal;
  logic          inst_invalid;
  logic          br_cond;

  always_ff @(posedge i_clk) begin
    if (i_rst) ds_valid <= 1'b0;
    else if (o_ds_allowin) ds_valid <= i_fs_to_ds_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) ds_r <= i_fs_to_ds;
  end

  assign opcode = ds_r.inst[6:0];
  assign rd     = ds_r.inst[11:7];
  assign funct3 = ds_r.inst[14:12];
  assign rs1    = ds_r.inst[19:15];
  assign rs2    = ds_r.inst[24:20];
  assign funct7 = ds_r.inst[31:25];

  assign is_addi = (opcode == 7'b0010011) && (funct3 == 3'b000);
  assign is_add  = (opcode == 7'b0110011) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign is_sub  = (opcode == 7'b0110011) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  assign is_lw   = (opcode == 7'b0000011) && (funct3 == 3'b010);
  assign is_sw   = (opcode == 7'b0100011) && (funct3 == 3'b010);
  assign is_beq  = (opcode == 7'b1100011) && (funct3 == 3'b000);
  assign is_bne  = (opcode == 7'b1100011) && (funct3 == 3'b001);
  assign is_jal  = (opcode == 7'b1101111);

  // anything else runs as a nop
  assign inst_invalid = ds_valid &&
    !(is_addi || is_add || is_sub || is_lw || is_sw || is_beq || is_bne || is_jal);

  always_comb begin
    if (is_sw) imm = {{20{ds_r.inst[31]}}, ds_r.inst[31:25], ds_r.inst[11:7]};
    else if (is_beq || is_bne)
      imm = {{19{ds_r.inst[31]}}, ds_r.inst[31], ds_r.inst[7], ds_r.inst[30:25],
             ds_r.inst[11:8], 1'b0};
    else if (is_jal)
      imm = {{11{ds_r.inst[31]}}, ds_r.inst[31], ds_r.inst[19:12], ds_r.inst[20],
             ds_r.inst[30:21], 1'b0};
    else imm = {{20{ds_r.inst[31]}}, ds_r.inst[31:20]};
  end

  rv_regfile u_regfile (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_write  (i_rf_write)
  );

  // raw hazard against the one instruction in execute
  assign ds_ready_go = !(i_es_rd_valid && i_es_rd != '0 && (i_es_rd == rs1 || i_es_rd == rs2));
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  assign br_cond      = is_jal || (is_beq && rs1_data == rs2_data) ||
                        (is_bne && rs1_data != rs2_data);
  assign o_br.taken   = ds_valid && ds_ready_go && i_es_allowin && br_cond;
  assign o_br.target  = ds_r.pc + imm;

  always_comb begin
    o_ds_to_es.src_a    = is_jal ? ds_r.pc : rs1_data; // jal links pc+4
    o_ds_to_es.src_b    = is_jal ? word_t'(4) : (is_addi ? imm : rs2_data);
    o_ds_to_es.imm      = imm;
    o_ds_to_es.alu_op   = is_sub ? ALU_SUB : ALU_ADD;
    o_ds_to_es.rd       = rd;
    o_ds_to_es.rf_we    = is_addi || is_add || is_sub || is_lw || is_jal;
    o_ds_to_es.is_load  = is_lw;
    o_ds_to_es.is_store = is_sw;
  end

endmodule

//--- logic/rv_fetch_stage.sv
// fetch stage, pc register and wishbone instruction reads with branch redirect
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_fetch_stage import rv_core_pkg::*; (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_ds_allowin,
  output logic          o_fs_to_ds_valid,
  output fetch_to_dec_t o_fs_to_ds,
  input  br_bus_t       i_br,
  output wb_req_t       o_wb_req,
  input  wb_rsp_t       i_wb_rsp
);

  fetch_state_e state;
  pc_t          pc;
  pc_t          redir_pc; // target parked while a stale read drains
  inst_t        fs_inst;
  logic         fs_valid;

  assign o_fs_to_ds_valid = fs_valid && !i_br.taken; // word after a taken branch is dead
  assign o_fs_to_ds       = '{pc: pc, inst: fs_inst};

  always_comb begin
    o_wb_req     = '0;
    o_wb_req.adr = pc;
    o_wb_req.sel = 4'hf;
    o_wb_req.cyc = (state != FS_IDLE);
    o_wb_req.stb = (state != FS_IDLE);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= FS_IDLE;
      pc       <= `RV_RESET_PC;
      fs_valid <= 1'b0;
    end else begin
      case (state)
        FS_IDLE: begin
          if (i_br.taken) begin
            pc       <= i_br.target;
            fs_valid <= 1'b0;
            state    <= FS_REQ;
          end else if (!fs_valid) begin
            state <= FS_REQ;
          end else if (i_ds_allowin) begin
            pc       <= pc + pc_t'(4);
            fs_valid <= 1'b0;
            state    <= FS_REQ;
          end
        end
        FS_REQ: begin
          if (i_wb_rsp.ack) begin
            state <= FS_IDLE;
            if (i_br.taken) pc <= i_br.target; // data thrown away
            else fs_valid <= 1'b1;
          end else if (i_br.taken) begin
            state <= FS_DROP;
          end
        end
        FS_DROP: begin
          if (i_wb_rsp.ack) begin
            pc    <= redir_pc;
            state <= FS_IDLE;
          end
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == FS_REQ && i_wb_rsp.ack) fs_inst <= i_wb_rsp.dat_r;
    if (state == FS_REQ && !i_wb_rsp.ack && i_br.taken) redir_pc <= i_br.target;
  end

endmodule

//--- logic/rv_regfile.sv
// integer register file, two read ports and one write port with write-through
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_regfile import rv_core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_raddr1,
  input  reg_addr_t i_raddr2,
  output word_t     o_rdata1,
  output word_t     o_rdata2,
  input  rf_write_t i_write
);

  word_t regs [`RV_NREGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `RV_NREGS; i++) regs[i] <= '0;
    end else if (i_write.wen && i_write.waddr != '0) begin
      regs[i_write.waddr] <= i_write.wdata;
    end
  end

  // bypass the value being written this cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 :
                    (i_write.wen && i_write.waddr == i_raddr1) ? i_write.wdata : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 :
                    (i_write.wen && i_write.waddr == i_raddr2) ? i_write.wdata : regs[i_raddr2];

endmodule

//--- logic/rv_core_pkg.sv
// shared types for the three stage rv32i core and its wishbone port
`include "rv_core_cfg.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_XLEN-1:0] pc_t;
  typedef logic [`RV_XLEN-1:0] inst_t;
  typedef logic [4:0]          reg_addr_t;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB} alu_op_e;
  typedef enum logic [1:0] {FS_IDLE, FS_REQ, FS_DROP} fetch_state_e;
  typedef enum logic {ES_IDLE, ES_BUS} exec_state_e;
  typedef enum logic [1:0] {GNT_IDLE, GNT_FETCH, GNT_EXEC} grant_e; // bus owner

  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_to_dec_t;

  typedef struct packed {
    logic taken;
    pc_t  target;
  } br_bus_t;

  // src_b carries store data, src_a the base
  typedef struct packed {
    word_t     src_a;
    word_t     src_b;
    word_t     imm;
    alu_op_e   alu_op;
    reg_addr_t rd;
    logic      rf_we;
    logic      is_load;
    logic      is_store;
  } dec_to_exe_t;

  typedef struct packed {
    word_t      adr;
    word_t      dat_w;
    logic [3:0] sel;
    logic       we;
    logic       cyc;
    logic       stb;
  } wb_req_t;

  typedef struct packed {
    word_t dat_r;
    logic  ack;
  } wb_rsp_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_write_t;

endpackage

//--- logic/rv_core_cfg.svh
// width, register count and reset pc for the rv32i core
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0

// architectural registers, x0 included
`define RV_NREGS 32

`endif
